// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator and run; pass only if the pass line shows up in the output
verilator --binary --timing -j 0 --top-module tb_periph_subsys -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== source/clkgen_regs.sv ====
// Clock generation register block
// PLL configuration, output divider and crystal oscillator enable

`timescale 1ns/100ps

module clkgen_regs import periph_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Register port
  input  logic              i_wr,
  input  logic [OFFS_W-1:0] i_offset,
  input  logic [DATA_W-1:0] i_wdata,
  output logic [DATA_W-1:0] o_rdata,
  // Clock controls
  output logic              o_pll_bypass,
  output logic              o_pll_reset,
  output logic              o_pll_asleep,
  output logic [1:0]        o_pll_od,
  output logic [7:0]        o_pll_m,
  output logic [4:0]        o_pll_n,
  output logic              o_pll_outdivby1,
  output logic [5:0]        o_pll_outdiv,
  output logic              o_hfxoscen
);

  pll_cfg_u   pll_q;
  logic [6:0] outdiv_q;
  logic       hfxosc_q;

  // Oscillator on, PLL bypassed and held in reset after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pll_q.raw <= PLLCFG_RST;
      outdiv_q  <= OUTDIV_RST[6:0];
      hfxosc_q  <= 1'b1;
    end else if (i_wr) begin
      case (i_offset)
        CLK_PLLCFG_OFS: pll_q.raw <= i_wdata;
        CLK_OUTDIV_OFS: outdiv_q  <= i_wdata[6:0];
        CLK_HFXOSC_OFS: hfxosc_q  <= i_wdata[0];
        default: ;
      endcase
    end
  end

  // Raw word back to the bus
  always_comb begin
    case (i_offset)
      CLK_PLLCFG_OFS: o_rdata = pll_q.raw;
      CLK_OUTDIV_OFS: o_rdata = DATA_W'(outdiv_q);
      CLK_HFXOSC_OFS: o_rdata = DATA_W'(hfxosc_q);
      default:        o_rdata = '0;
    endcase
  end

  // Field view drives the PLL pins
  assign o_pll_bypass    = pll_q.f.bypass;
  assign o_pll_reset     = pll_q.f.reset;
  assign o_pll_asleep    = pll_q.f.asleep;
  assign o_pll_od        = pll_q.f.od;
  assign o_pll_m         = pll_q.f.m;
  assign o_pll_n         = pll_q.f.n;
  // Bit 6 bypasses the divider
  assign o_pll_outdivby1 = outdiv_q[6];
  assign o_pll_outdiv    = outdiv_q[5:0];
  assign o_hfxoscen      = hfxosc_q;

endmodule

// ==== source/gpio_regs.sv ====
// GPIO register block
// Pad control registers, synchronised pad inputs and rising-edge interrupts

`timescale 1ns/100ps

module gpio_regs import periph_pkg::*; #(
  parameter int GPIO_W = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  // Register port
  input  logic              i_wr,
  input  logic [OFFS_W-1:0] i_offset,
  input  logic [DATA_W-1:0] i_wdata,
  output logic [DATA_W-1:0] o_rdata,
  // Pads
  input  logic [GPIO_W-1:0] i_gpio_in,
  output logic [GPIO_W-1:0] o_gpio_out,
  output logic [GPIO_W-1:0] o_gpio_oe,
  output logic [GPIO_W-1:0] o_gpio_ie,
  output logic [GPIO_W-1:0] o_gpio_pue,
  output logic [GPIO_W-1:0] o_gpio_ds,
  output logic [GPIO_W-1:0] o_gpio_irq
);

  logic [SYNC_STAGES-1:0][GPIO_W-1:0] sync_q;
  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] value;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] ip_clr;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] ie_q;
  logic [GPIO_W-1:0] pue_q;
  logic [GPIO_W-1:0] ds_q;
  logic [GPIO_W-1:0] rise_ie_q;
  logic [GPIO_W-1:0] rise_ip_q;

  // Oldest stage is the synchronised value
  assign value = sync_q[SYNC_STAGES-1];
  // Only pins with both enables can flag an edge
  assign rise = value & ~prev_q & ie_q & rise_ie_q;
  // Write one to clear
  assign ip_clr = (i_wr && i_offset == GPIO_RISE_IP_OFS) ? i_wdata[GPIO_W-1:0] : '0;

  // Pad input synchroniser and edge history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], i_gpio_in};
      prev_q <= value;
    end
  end

  // Control registers, a new edge wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_q     <= '0;
      oe_q      <= '0;
      ie_q      <= '0;
      pue_q     <= '0;
      ds_q      <= '0;
      rise_ie_q <= '0;
      rise_ip_q <= '0;
    end else begin
      if (i_wr) begin
        case (i_offset)
          GPIO_OUT_OFS:     out_q     <= i_wdata[GPIO_W-1:0];
          GPIO_OE_OFS:      oe_q      <= i_wdata[GPIO_W-1:0];
          GPIO_IE_OFS:      ie_q      <= i_wdata[GPIO_W-1:0];
          GPIO_PUE_OFS:     pue_q     <= i_wdata[GPIO_W-1:0];
          GPIO_DS_OFS:      ds_q      <= i_wdata[GPIO_W-1:0];
          GPIO_RISE_IE_OFS: rise_ie_q <= i_wdata[GPIO_W-1:0];
          default: ;
        endcase
      end
      rise_ip_q <= (rise_ip_q & ~ip_clr) | rise;
    end
  end

  // Read mux, undefined offsets read zero
  always_comb begin
    case (i_offset)
      GPIO_VALUE_OFS:   o_rdata = DATA_W'(value);
      GPIO_IE_OFS:      o_rdata = DATA_W'(ie_q);
      GPIO_OE_OFS:      o_rdata = DATA_W'(oe_q);
      GPIO_OUT_OFS:     o_rdata = DATA_W'(out_q);
      GPIO_PUE_OFS:     o_rdata = DATA_W'(pue_q);
      GPIO_DS_OFS:      o_rdata = DATA_W'(ds_q);
      GPIO_RISE_IE_OFS: o_rdata = DATA_W'(rise_ie_q);
      GPIO_RISE_IP_OFS: o_rdata = DATA_W'(rise_ip_q);
      default:          o_rdata = '0;
    endcase
  end

  assign o_gpio_out = out_q;
  assign o_gpio_oe  = oe_q;
  assign o_gpio_ie  = ie_q;
  assign o_gpio_pue = pue_q;
  assign o_gpio_ds  = ds_q;
  assign o_gpio_irq = rise_ip_q & rise_ie_q;

endmodule

// ==== source/periph_pkg.sv ====
// Peripheral subsystem definitions
// Bus widths, register map offsets, reset values and the PLL config layout

package periph_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // Offset bits inside one 4 KB region
  localparam int OFFS_W = 12;

  // GPIO register map
  localparam logic [OFFS_W-1:0] GPIO_VALUE_OFS   = 12'h000;
  localparam logic [OFFS_W-1:0] GPIO_IE_OFS      = 12'h004;
  localparam logic [OFFS_W-1:0] GPIO_OE_OFS      = 12'h008;
  localparam logic [OFFS_W-1:0] GPIO_OUT_OFS     = 12'h00C;
  localparam logic [OFFS_W-1:0] GPIO_PUE_OFS     = 12'h010;
  localparam logic [OFFS_W-1:0] GPIO_DS_OFS      = 12'h014;
  localparam logic [OFFS_W-1:0] GPIO_RISE_IE_OFS = 12'h018;
  localparam logic [OFFS_W-1:0] GPIO_RISE_IP_OFS = 12'h01C;

  // Clock generation register map
  localparam logic [OFFS_W-1:0] CLK_HFXOSC_OFS = 12'h000;
  localparam logic [OFFS_W-1:0] CLK_PLLCFG_OFS = 12'h004;
  localparam logic [OFFS_W-1:0] CLK_OUTDIV_OFS = 12'h008;

  // PLL config word, LSB first is n, m, od, bypass, reset, asleep
  typedef struct packed {
    logic [13:0] rsvd;
    logic        asleep;
    logic        reset;
    logic        bypass;
    logic [1:0]  od;
    logic [7:0]  m;
    logic [4:0]  n;
  } pll_cfg_t;

  // Same word seen from the bus or as fields
  typedef union packed {
    logic [DATA_W-1:0] raw;
    pll_cfg_t          f;
  } pll_cfg_u;

  // PLL held in bypass and reset out of reset
  localparam logic [DATA_W-1:0] PLLCFG_RST = 32'h0001_8000;
  // Divide-by-one set, divider 0
  localparam logic [DATA_W-1:0] OUTDIV_RST = 32'h0000_0040;

  // Pad input synchroniser depth
  localparam int SYNC_STAGES = 2;

endpackage

// ==== source/periph_subsys.sv ====
// Peripheral subsystem top
// Bus fabric in front of the GPIO and clock generation register blocks

`timescale 1ns/100ps

module periph_subsys import periph_pkg::*; #(
  parameter logic [ADDR_W-1:0] GPIO_BASE_ADDR   = 32'h1001_2000,
  parameter logic [ADDR_W-1:0] CLKGEN_BASE_ADDR = 32'h1000_8000,
  parameter int                REGION_LSB       = 12,
  parameter int                GPIO_W           = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  // Command channel
  input  logic              i_cmd_valid,
  output logic              o_cmd_ready,
  input  logic [ADDR_W-1:0] i_cmd_addr,
  input  logic              i_cmd_read,
  input  logic [DATA_W-1:0] i_cmd_wdata,
  // Response channel
  output logic              o_rsp_valid,
  output logic              o_rsp_err,
  output logic [DATA_W-1:0] o_rsp_rdata,
  input  logic              i_rsp_ready,
  // GPIO pads
  input  logic [GPIO_W-1:0] i_gpio_in,
  output logic [GPIO_W-1:0] o_gpio_out,
  output logic [GPIO_W-1:0] o_gpio_oe,
  output logic [GPIO_W-1:0] o_gpio_ie,
  output logic [GPIO_W-1:0] o_gpio_pue,
  output logic [GPIO_W-1:0] o_gpio_ds,
  output logic [GPIO_W-1:0] o_gpio_irq,
  // Clock controls
  output logic              o_pll_bypass,
  output logic              o_pll_reset,
  output logic              o_pll_asleep,
  output logic [1:0]        o_pll_od,
  output logic [7:0]        o_pll_m,
  output logic [4:0]        o_pll_n,
  output logic              o_pll_outdivby1,
  output logic [5:0]        o_pll_outdiv,
  output logic              o_hfxoscen
);

  logic              gpio_wr;
  logic              clk_wr;
  logic [OFFS_W-1:0] reg_offset;
  logic [DATA_W-1:0] reg_wdata;
  logic [DATA_W-1:0] gpio_rdata;
  logic [DATA_W-1:0] clk_rdata;

  ppi_fabric #(
    .GPIO_BASE_ADDR   (GPIO_BASE_ADDR),
    .CLKGEN_BASE_ADDR (CLKGEN_BASE_ADDR),
    .REGION_LSB       (REGION_LSB)
  ) u_fabric (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cmd_valid  (i_cmd_valid),
    .o_cmd_ready  (o_cmd_ready),
    .i_cmd_addr   (i_cmd_addr),
    .i_cmd_read   (i_cmd_read),
    .i_cmd_wdata  (i_cmd_wdata),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_err    (o_rsp_err),
    .o_rsp_rdata  (o_rsp_rdata),
    .i_rsp_ready  (i_rsp_ready),
    .o_gpio_wr    (gpio_wr),
    .o_offset     (reg_offset),
    .o_wdata      (reg_wdata),
    .i_gpio_rdata (gpio_rdata),
    .o_clk_wr     (clk_wr),
    .i_clk_rdata  (clk_rdata)
  );

  gpio_regs #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wr       (gpio_wr),
    .i_offset   (reg_offset),
    .i_wdata    (reg_wdata),
    .o_rdata    (gpio_rdata),
    .i_gpio_in  (i_gpio_in),
    .o_gpio_out (o_gpio_out),
    .o_gpio_oe  (o_gpio_oe),
    .o_gpio_ie  (o_gpio_ie),
    .o_gpio_pue (o_gpio_pue),
    .o_gpio_ds  (o_gpio_ds),
    .o_gpio_irq (o_gpio_irq)
  );

  clkgen_regs u_clkgen (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_wr            (clk_wr),
    .i_offset        (reg_offset),
    .i_wdata         (reg_wdata),
    .o_rdata         (clk_rdata),
    .o_pll_bypass    (o_pll_bypass),
    .o_pll_reset     (o_pll_reset),
    .o_pll_asleep    (o_pll_asleep),
    .o_pll_od        (o_pll_od),
    .o_pll_m         (o_pll_m),
    .o_pll_n         (o_pll_n),
    .o_pll_outdivby1 (o_pll_outdivby1),
    .o_pll_outdiv    (o_pll_outdiv),
    .o_hfxoscen      (o_hfxoscen)
  );

endmodule

// ==== source/ppi_fabric.sv ====
// Peripheral bus fabric
// Decodes the command address to GPIO or clock block, one transaction in flight

`timescale 1ns/100ps

module ppi_fabric import periph_pkg::*; #(
  parameter logic [ADDR_W-1:0] GPIO_BASE_ADDR   = 32'h1001_2000,
  parameter logic [ADDR_W-1:0] CLKGEN_BASE_ADDR = 32'h1000_8000,
  parameter int                REGION_LSB       = 12
) (
  input  logic              clk,
  input  logic              rst_n,
  // Command channel
  input  logic              i_cmd_valid,
  output logic              o_cmd_ready,
  input  logic [ADDR_W-1:0] i_cmd_addr,
  input  logic              i_cmd_read,
  input  logic [DATA_W-1:0] i_cmd_wdata,
  // Response channel
  output logic              o_rsp_valid,
  output logic              o_rsp_err,
  output logic [DATA_W-1:0] o_rsp_rdata,
  input  logic              i_rsp_ready,
  // GPIO block
  output logic              o_gpio_wr,
  output logic [OFFS_W-1:0] o_offset,
  output logic [DATA_W-1:0] o_wdata,
  input  logic [DATA_W-1:0] i_gpio_rdata,
  // Clock generation block
  output logic              o_clk_wr,
  input  logic [DATA_W-1:0] i_clk_rdata
);

  logic              rsp_valid_q;
  logic              rsp_err_q;
  logic [DATA_W-1:0] rsp_rdata_q;

  logic              cmd_fire;
  logic              rsp_fire;
  logic              hit_gpio;
  logic              hit_clk;
  logic              hit_any;
  logic [DATA_W-1:0] sel_rdata;

  // New command only when nothing is held
  assign o_cmd_ready = ~rsp_valid_q;
  assign cmd_fire    = i_cmd_valid & o_cmd_ready;
  assign rsp_fire    = rsp_valid_q & i_rsp_ready;

  // Region match on the bits above the offset
  assign hit_gpio = (i_cmd_addr[ADDR_W-1:REGION_LSB] == GPIO_BASE_ADDR[ADDR_W-1:REGION_LSB]);
  assign hit_clk  = (i_cmd_addr[ADDR_W-1:REGION_LSB] == CLKGEN_BASE_ADDR[ADDR_W-1:REGION_LSB]);
  assign hit_any  = hit_gpio | hit_clk;

  // Offset and data go to both blocks, strobes pick one
  assign o_offset  = i_cmd_addr[OFFS_W-1:0];
  assign o_wdata   = i_cmd_wdata;
  assign o_gpio_wr = cmd_fire & ~i_cmd_read & hit_gpio;
  assign o_clk_wr  = cmd_fire & ~i_cmd_read & hit_clk;

  // Read data source, zero for writes and unmapped addresses
  always_comb begin
    sel_rdata = '0;
    if (i_cmd_read) begin
      if (hit_gpio) begin
        sel_rdata = i_gpio_rdata;
      end else if (hit_clk) begin
        sel_rdata = i_clk_rdata;
      end
    end
  end

  // Response valid flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (cmd_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_fire) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Response payload, captured at acceptance and held until transfer
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      rsp_err_q   <= ~hit_any;
      rsp_rdata_q <= sel_rdata;
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp_err   = rsp_err_q;
  assign o_rsp_rdata = rsp_rdata_q;

endmodule

// ==== tb.f ====
source/periph_pkg.sv
source/ppi_fabric.sv
source/gpio_regs.sv
source/clkgen_regs.sv
source/periph_subsys.sv
verif/periph_checker.sv
verif/tb_periph_subsys.sv

// ==== verif/periph_checker.sv ====
// Peripheral subsystem checker
// Watches DUT ports and compares responses and outputs with expected values

`timescale 1ns/100ps

module periph_checker (
  input  logic         clk,
  input  logic         rst_n,
  // Bus handshake as seen at the DUT
  input  logic         i_cmd_valid,
  input  logic         i_cmd_ready,
  input  logic         i_rsp_valid,
  input  logic         i_rsp_ready,
  input  logic         i_rsp_err,
  input  logic [31:0]  i_rsp_rdata,
  // Pad and clock outputs
  input  logic [31:0]  i_gpio_out,
  input  logic [31:0]  i_gpio_oe,
  input  logic [31:0]  i_gpio_ie,
  input  logic [31:0]  i_gpio_pue,
  input  logic [31:0]  i_gpio_ds,
  input  logic [31:0]  i_gpio_irq,
  input  logic [4:0]   i_pll_n,
  input  logic [7:0]   i_pll_m,
  input  logic [1:0]   i_pll_od,
  input  logic         i_pll_bypass,
  input  logic         i_pll_reset,
  input  logic         i_pll_asleep,
  input  logic         i_pll_outdivby1,
  input  logic [5:0]   i_pll_outdiv,
  input  logic         i_hfxoscen,
  // Expectation of the current test
  input  logic [159:0] i_name,
  input  logic [31:0]  i_exp_data,
  input  logic         i_exp_err,
  input  logic         i_port_chk,
  input  logic [3:0]   i_port_sel,
  output int           o_pass_cnt,
  output int           o_fail_cnt,
  output logic         o_pending
);

  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cmd_cnt = 0;
  int          rsp_cnt = 0;
  logic        held_q = 1'b0;
  logic        acc_q = 1'b0;
  logic [31:0] last_rdata_q = '0;
  logic        last_err_q = 1'b0;
  logic [31:0] port_val;

  // Output picked by the port selector
  always_comb begin
    case (i_port_sel)
      4'h0:    port_val = i_gpio_out;
      4'h1:    port_val = i_gpio_oe;
      4'h2:    port_val = i_gpio_ie;
      4'h3:    port_val = i_gpio_pue;
      4'h4:    port_val = i_gpio_ds;
      4'h5:    port_val = i_gpio_irq;
      4'h6:    port_val = 32'(i_pll_n);
      4'h7:    port_val = 32'(i_pll_m);
      4'h8:    port_val = 32'(i_pll_od);
      4'h9:    port_val = 32'(i_pll_bypass);
      4'ha:    port_val = 32'(i_pll_reset);
      4'hb:    port_val = 32'(i_pll_asleep);
      4'hc:    port_val = 32'(i_pll_outdivby1);
      4'hd:    port_val = 32'(i_pll_outdiv);
      default: port_val = 32'(i_hfxoscen);
    endcase
  end

  // One line per finished test
  task automatic compare_result(input logic [159:0] name, input logic [31:0] exp_d,
                                input logic exp_e, input logic [31:0] act_d,
                                input logic act_e);
    if (exp_d !== act_d || exp_e !== act_e) begin
      $display("[ERROR] %0s expected %08h err %0d, actual %08h err %0d",
               name, exp_d, exp_e, act_d, act_e);
      fail_cnt++;
    end else begin
      $display("ok      %0s data %08h err %0d", name, act_d, act_e);
      pass_cnt++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      // Single outstanding transaction
      if (i_rsp_valid && i_cmd_ready) begin
        $display("Command ready was high while a response was held");
        fail_cnt++;
      end
      // Response valid one cycle after acceptance
      if (acc_q && !i_rsp_valid) begin
        $display("The response did not follow its command by one cycle");
        fail_cnt++;
      end
      // Stalled response must not move
      if (held_q && (!i_rsp_valid || i_rsp_rdata !== last_rdata_q ||
                     i_rsp_err !== last_err_q)) begin
        $display("A stalled response changed before it was taken");
        fail_cnt++;
      end
      if (i_rsp_valid && i_rsp_ready) begin
        rsp_cnt++;
        if (rsp_cnt != cmd_cnt) begin
          $display("A response arrived with no command waiting for it");
          fail_cnt++;
        end
        compare_result(i_name, i_exp_data, i_exp_err, i_rsp_rdata, i_rsp_err);
      end
      if (i_cmd_valid && i_cmd_ready) begin
        cmd_cnt++;
      end
      if (i_port_chk) begin
        compare_result(i_name, i_exp_data, 1'b0, port_val, 1'b0);
      end
      acc_q        <= i_cmd_valid && i_cmd_ready;
      held_q       <= i_rsp_valid && !i_rsp_ready;
      last_rdata_q <= i_rsp_rdata;
      last_err_q   <= i_rsp_err;
    end
  end

  assign o_pass_cnt = pass_cnt;
  assign o_fail_cnt = fail_cnt;
  // Command accepted but no response yet
  assign o_pending  = (cmd_cnt != rsp_cnt);

endmodule

// ==== verif/periph_testdata.txt ====
# name op addr_or_pad wdata exp_rdata exp_err (hex)
# op rd/wr is a bus access, pad drives pins, port checks the output picked by addr
rst_pllcfg    rd    10008004 00000000 00018000 0
rst_outdiv    rd    10008008 00000000 00000040 0
rst_hfxosc    rd    10008000 00000000 00000001 0
rst_bypass    port  9        00000000 00000001 0
rst_pllrst    port  a        00000000 00000001 0
rst_hfxen     port  e        00000000 00000001 0
rst_gpio_oe   rd    10012008 00000000 00000000 0
rst_rise_ip   rd    1001201c 00000000 00000000 0
wr_out        wr    1001200c a5a5f00f 00000000 0
rd_out        rd    1001200c 00000000 a5a5f00f 0
pin_out       port  0        00000000 a5a5f00f 0
wr_oe         wr    10012008 0000ffff 00000000 0
pin_oe        port  1        00000000 0000ffff 0
wr_pue        wr    10012010 12345678 00000000 0
rd_pue        rd    10012010 00000000 12345678 0
pin_pue       port  3        00000000 12345678 0
wr_ds         wr    10012014 87654321 00000000 0
pin_ds        port  4        00000000 87654321 0
wr_pll        wr    10008004 000254b3 00000000 0
rd_pll        rd    10008004 00000000 000254b3 0
pll_n         port  6        00000000 00000013 0
pll_m         port  7        00000000 000000a5 0
pll_od        port  8        00000000 00000002 0
pll_bypass    port  9        00000000 00000000 0
pll_asleep    port  b        00000000 00000001 0
wr_outdiv     wr    10008008 0000002a 00000000 0
pin_divby1    port  c        00000000 00000000 0
pin_div       port  d        00000000 0000002a 0
unmap_rd      rd    10010000 00000000 00000000 1
unmap_wr      wr    10010000 ffffffff 00000000 1
undef_ofs     rd    10012040 00000000 00000000 0
wr_ie         wr    10012004 00000005 00000000 0
pin_ie        port  2        00000000 00000005 0
wr_rise_ie    wr    10012018 00000004 00000000 0
pad_rise      pad   00000005 00000000 00000000 0
irq_set       port  5        00000000 00000004 0
rd_ip         rd    1001201c 00000000 00000004 0
rd_value      rd    10012000 00000000 00000005 0
clr_ip        wr    1001201c 00000004 00000000 0
irq_clr       port  5        00000000 00000000 0
rd_ip_clr     rd    1001201c 00000000 00000000 0

// ==== verif/tb_periph_subsys.sv ====
// Peripheral subsystem testbench
// Runs bus, pad and output checks from a data table with random response stalls

`timescale 1ns/100ps

module tb_periph_subsys;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         i_cmd_valid;
  logic         o_cmd_ready;
  logic [31:0]  i_cmd_addr;
  logic         i_cmd_read;
  logic [31:0]  i_cmd_wdata;
  logic         o_rsp_valid;
  logic         o_rsp_err;
  logic [31:0]  o_rsp_rdata;
  logic         i_rsp_ready;
  logic [31:0]  i_gpio_in;
  logic [31:0]  o_gpio_out;
  logic [31:0]  o_gpio_oe;
  logic [31:0]  o_gpio_ie;
  logic [31:0]  o_gpio_pue;
  logic [31:0]  o_gpio_ds;
  logic [31:0]  o_gpio_irq;
  logic         o_pll_bypass;
  logic         o_pll_reset;
  logic         o_pll_asleep;
  logic [1:0]   o_pll_od;
  logic [7:0]   o_pll_m;
  logic [4:0]   o_pll_n;
  logic         o_pll_outdivby1;
  logic [5:0]   o_pll_outdiv;
  logic         o_hfxoscen;

  // Current expectation handed to the checker
  logic [159:0] cur_name;
  logic [31:0]  exp_data;
  logic         exp_err;
  logic         port_chk;
  logic [3:0]   port_sel;
  int           pass_cnt;
  int           fail_cnt;
  logic         pending;

  // Table loaded from the data file
  logic [159:0] q_name[$];
  string        q_op[$];
  logic [31:0]  q_a[$];
  logic [31:0]  q_wd[$];
  logic [31:0]  q_er[$];
  logic         q_ee[$];

  string        line;
  logic [159:0] f_name;
  string        f_op;
  logic [31:0]  f_a;
  logic [31:0]  f_wd;
  logic [31:0]  f_er;
  logic [31:0]  f_ee;
  int           fd;
  int           n_read;
  int           n_fields;
  int           n_checks = 0;
  int           bad_ops = 0;
  logic [31:0]  rnd_state = 32'd45091;
  int           cycle_cnt = 0;
  int           cycle_limit = 0;

  always #50 clk = ~clk;

  periph_subsys #(
    .GPIO_W (32)
  ) DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_cmd_valid     (i_cmd_valid),
    .o_cmd_ready     (o_cmd_ready),
    .i_cmd_addr      (i_cmd_addr),
    .i_cmd_read      (i_cmd_read),
    .i_cmd_wdata     (i_cmd_wdata),
    .o_rsp_valid     (o_rsp_valid),
    .o_rsp_err       (o_rsp_err),
    .o_rsp_rdata     (o_rsp_rdata),
    .i_rsp_ready     (i_rsp_ready),
    .i_gpio_in       (i_gpio_in),
    .o_gpio_out      (o_gpio_out),
    .o_gpio_oe       (o_gpio_oe),
    .o_gpio_ie       (o_gpio_ie),
    .o_gpio_pue      (o_gpio_pue),
    .o_gpio_ds       (o_gpio_ds),
    .o_gpio_irq      (o_gpio_irq),
    .o_pll_bypass    (o_pll_bypass),
    .o_pll_reset     (o_pll_reset),
    .o_pll_asleep    (o_pll_asleep),
    .o_pll_od        (o_pll_od),
    .o_pll_m         (o_pll_m),
    .o_pll_n         (o_pll_n),
    .o_pll_outdivby1 (o_pll_outdivby1),
    .o_pll_outdiv    (o_pll_outdiv),
    .o_hfxoscen      (o_hfxoscen)
  );

  periph_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_cmd_valid     (i_cmd_valid),
    .i_cmd_ready     (o_cmd_ready),
    .i_rsp_valid     (o_rsp_valid),
    .i_rsp_ready     (i_rsp_ready),
    .i_rsp_err       (o_rsp_err),
    .i_rsp_rdata     (o_rsp_rdata),
    .i_gpio_out      (o_gpio_out),
    .i_gpio_oe       (o_gpio_oe),
    .i_gpio_ie       (o_gpio_ie),
    .i_gpio_pue      (o_gpio_pue),
    .i_gpio_ds       (o_gpio_ds),
    .i_gpio_irq      (o_gpio_irq),
    .i_pll_n         (o_pll_n),
    .i_pll_m         (o_pll_m),
    .i_pll_od        (o_pll_od),
    .i_pll_bypass    (o_pll_bypass),
    .i_pll_reset     (o_pll_reset),
    .i_pll_asleep    (o_pll_asleep),
    .i_pll_outdivby1 (o_pll_outdivby1),
    .i_pll_outdiv    (o_pll_outdiv),
    .i_hfxoscen      (o_hfxoscen),
    .i_name          (cur_name),
    .i_exp_data      (exp_data),
    .i_exp_err       (exp_err),
    .i_port_chk      (port_chk),
    .i_port_sel      (port_sel),
    .o_pass_cnt      (pass_cnt),
    .o_fail_cnt      (fail_cnt),
    .o_pending       (pending)
  );

  // xorshift32 step for response stalls
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One bus command and a random 0..3 cycle stall before taking the response
  task automatic bus_access(input logic rd, input logic [31:0] addr,
                            input logic [31:0] wdata);
    int stall;
    @(posedge clk);
    i_cmd_valid <= 1'b1;
    i_cmd_read  <= rd;
    i_cmd_addr  <= addr;
    i_cmd_wdata <= wdata;
    @(negedge clk);
    while (!o_cmd_ready) @(negedge clk);
    // Accepted on this edge
    @(posedge clk);
    i_cmd_valid <= 1'b0;
    rnd_state = next_random(rnd_state);
    stall = int'(rnd_state[1:0]);
    repeat (stall) @(posedge clk);
    i_rsp_ready <= 1'b1;
    @(negedge clk);
    while (!o_rsp_valid) @(negedge clk);
    @(posedge clk);
    i_rsp_ready <= 1'b0;
  endtask

  // Ask the checker to compare one output for one cycle
  task automatic port_check(input logic [3:0] sel);
    @(posedge clk);
    port_chk <= 1'b1;
    port_sel <= sel;
    @(posedge clk);
    port_chk <= 1'b0;
  endtask

  // Pad change followed by idle cycles for synchroniser and edge detect
  task automatic pad_drive(input logic [159:0] name, input logic [31:0] val);
    @(posedge clk);
    i_gpio_in <= val;
    repeat (5) @(posedge clk);
    $display("pad     %0s set to %08h", name, val);
  endtask

  // Hang guard at 30 cycles per table line plus margin
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst_n       = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd_addr  = '0;
    i_cmd_read  = 1'b0;
    i_cmd_wdata = '0;
    i_rsp_ready = 1'b0;
    i_gpio_in   = '0;
    cur_name    = '0;
    exp_data    = '0;
    exp_err     = 1'b0;
    port_chk    = 1'b0;
    port_sel    = '0;
    fd = $fopen("verif/periph_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        n_read = $fgets(line, fd);
        // Skip comment lines and the empty read at end of file
        if (n_read > 0 && line.getc(0) != "#") begin
          n_fields = $sscanf(line, "%s %s %h %h %h %h",
                             f_name, f_op, f_a, f_wd, f_er, f_ee);
          if (n_fields == 6) begin
            q_name.push_back(f_name);
            q_op.push_back(f_op);
            q_a.push_back(f_a);
            q_wd.push_back(f_wd);
            q_er.push_back(f_er);
            q_ee.push_back(f_ee[0]);
          end
        end
      end
      $fclose(fd);
      cycle_limit = 30 * q_op.size() + 50;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < q_op.size(); i++) begin
        @(posedge clk);
        cur_name <= q_name[i];
        exp_data <= q_er[i];
        exp_err  <= q_ee[i];
        if (q_op[i] == "rd" || q_op[i] == "wr") begin
          n_checks++;
          bus_access(q_op[i] == "rd", q_a[i], q_wd[i]);
        end else if (q_op[i] == "port") begin
          n_checks++;
          port_check(q_a[i][3:0]);
        end else if (q_op[i] == "pad") begin
          pad_drive(q_name[i], q_a[i]);
        end else begin
          $display("Unknown operation %s in test %0s", q_op[i], q_name[i]);
          bad_ops++;
        end
      end
      // Let the checker see the last edge
      repeat (2) @(posedge clk);
      $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && bad_ops == 0 && !pending && pass_cnt == n_checks) begin
        $display("RESULT: PASS");
      end else begin
        if (pending) begin
          $display("A command never got its response");
        end
        if (pass_cnt + fail_cnt < n_checks) begin
          $display("Fewer checks ran than the table holds");
        end
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule
